// File: src.f
logic/oht_pkg.sv
logic/es_health_test.sv
logic/es_sample_buffer.sv
logic/bit_compactor.sv
logic/cond_fifo.sv
logic/oht_top.sv
tests/oht_properties.sv
tests/oht_tb.sv

// File: run.sh
#!/bin/sh
# build and run the oht testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module oht_tb \
    -Mdir obj_dir -o oht_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/oht_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1

// File: tests/oht_tb.sv
`timescale 1ns/100ps

module oht_tb import oht_pkg::*; ();

    localparam int src_w        = $clog2(es_sources);
    localparam int reset_cycles = 16;
    localparam int max_run      = 5;    // healthy sources never repeat longer
    localparam int timeout      = 1000; // cycles per wait loop
    localparam int num_rows     = 5;

    typedef struct packed {
        logic [es_sources-1:0] stuck_mask;
        logic [es_sources-1:0] stuck_val;
        logic [es_sources-1:0] exp_good;   // rd_good_arr after warm-up
        int                    cycles;     // row length when popping
        logic                  pop_always; // 0 = hold off until full
    } row_t;

    localparam row_t rows [num_rows] = '{
        '{16'h0000, 16'h0000, 16'hffff, 300, 1'b1},  // all healthy
        '{16'h1008, 16'h0008, 16'heff7, 300, 1'b1},  // latch 3 and jitter 12 stuck
        '{16'h30c1, 16'h2041, 16'hcf3e, 300, 1'b1},
        '{16'h0080, 16'h0000, 16'hff7f, 0,   1'b0},  // back-pressure
        '{16'hffff, 16'ha5a5, 16'h0000, 200, 1'b1}   // nothing healthy
    };

    logic                  clk;
    logic                  rst;
    logic [es_sources-1:0] es_in;
    logic                  deque;
    logic [cond_width-1:0] cond_out;
    logic                  full;
    logic                  empty;
    logic [es_sources-1:0] rd_good_arr;

    row_t                  cur_row;
    logic [15:0]           lfsr_state;
    logic                  last_bit [es_sources]; // run tracking per source
    int                    run_len [es_sources];
    int                    sample_idx;            // samples driven since reset
    logic [cond_width-1:0] model_acc;
    int                    model_fill;
    logic [cond_width-1:0] exp_words [$];         // model output, oldest first
    int                    pops;

    always #5 clk = ~clk;

    oht_top u_oht_top (
        .clk         (clk),
        .rst         (rst),
        .es_in       (es_in),
        .deque       (deque),
        .cond_out    (cond_out),
        .full        (full),
        .empty       (empty),
        .rd_good_arr (rd_good_arr)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic make_sample(output logic [es_sources-1:0] s);
        logic [src_w-1:0] src;
        logic             b;
        s = '0;
        for (int i = 0; i < es_sources; i++) begin
            src = src_w'(i);
            if (cur_row.stuck_mask[src]) begin
                b = cur_row.stuck_val[src];
            end else begin
                lfsr_state = lfsr_next(lfsr_state); // one step per bit
                b = lfsr_state[0];
                if (sample_idx > 0 && b == last_bit[src] && run_len[src] == max_run)
                    b = !b; // break the run
            end
            run_len[src]  = (sample_idx == 0 || b != last_bit[src]) ? 1 : run_len[src] + 1;
            last_bit[src] = b;
            s[src]        = b;
        end
    endtask

    // alternate halves, keep good bits lowest first, pack 32 at a time
    task automatic model_add(input logic [es_sources-1:0] s);
        logic [sample_width-1:0] half;
        logic [sample_width-1:0] keep;
        int                      word_idx;
        word_idx = sample_idx - warmup_samples; // writes begin after warm-up
        if (word_idx >= 0) begin
            half = word_idx[0] ? s[es_sources-1 -: sample_width] : s[sample_width-1:0];
            keep = word_idx[0] ? cur_row.exp_good[es_sources-1 -: sample_width]
                               : cur_row.exp_good[sample_width-1:0];
            for (int b = 0; b < sample_width; b++) begin
                if (keep[0]) begin
                    model_acc  = model_acc | (cond_width'(half[0]) << model_fill);
                    model_fill = model_fill + 1;
                end
                if (model_fill == cond_width) begin
                    exp_words.push_back(model_acc);
                    model_acc  = '0;
                    model_fill = 0;
                end
                half = half >> 1;
                keep = keep >> 1;
            end
        end
    endtask

    // drive 1 ns after the edge, look at outputs on the falling edge
    task automatic step_cycle(input logic pop);
        logic [es_sources-1:0] s;
        @(posedge clk);
        #1;
        make_sample(s);
        model_add(s);
        rst        = 1'b1;
        es_in      = s;
        deque      = pop;
        sample_idx = sample_idx + 1;
        @(negedge clk);
        check_value("rd_good_arr", 32'(rd_good_arr),
                    sample_idx > warmup_samples ? 32'(cur_row.exp_good) : 32'h0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst        = 1'b0;
        es_in      = '0;
        deque      = 1'b0;
        sample_idx = 0;
        model_acc  = '0;
        model_fill = 0;
        pops       = 0;
        exp_words.delete();
        repeat (reset_cycles - 1) @(posedge clk); // first step releases rst
        @(negedge clk);
        check_value("empty", 32'(empty), 32'h1);
        check_value("full", 32'(full), 32'h0);
        check_value("rd_good_arr", 32'(rd_good_arr), 32'h0);
    endtask

    task automatic check_head();
        if (pops >= exp_words.size())
            fail_run("DUT delivered a word the model has not built yet");
        check_value("cond_out", cond_out, exp_words[pops]);
        pops = pops + 1;
    endtask

    task automatic wait_word();
        int timer;
        timer = 0;
        while (empty) begin
            step_cycle(1'b0);
            timer = timer + 1;
            if (timer > timeout) fail_run("timed out waiting for a word in the FIFO");
        end
    endtask

    initial begin
        int timer;
        clk        = 1'b0;
        rst        = 1'b0;
        es_in      = '0;
        deque      = 1'b0;
        lfsr_state = 16'd4614;
        for (int r = 0; r < num_rows; r++) begin
            cur_row = rows[r];
            apply_reset();
            if (cur_row.pop_always) begin
                for (int c = 0; c < cur_row.cycles; c++) begin
                    step_cycle(1'b1);
                    check_value("full", 32'(full), 32'h0);
                    if (cur_row.exp_good == '0)
                        check_value("empty", 32'(empty), 32'h1);
                    if (!empty)
                        check_head(); // deque is high, head leaves at next edge
                end
                if (cur_row.exp_good != '0 && pops < 10)
                    fail_run($sformatf("row %0d delivered only %0d words", r, pops));
            end else begin
                timer = 0;
                while (!full) begin
                    step_cycle(1'b0);
                    timer = timer + 1;
                    if (timer > timeout) fail_run("timed out waiting for the FIFO to fill");
                end
                repeat (20) begin // stalled, nothing may leave
                    step_cycle(1'b0);
                    check_value("full", 32'(full), 32'h1);
                    check_value("empty", 32'(empty), 32'h0);
                end
                for (int w = 0; w < fifo_depth; w++) begin
                    wait_word();
                    check_head();
                    step_cycle(1'b1);
                    step_cycle(1'b0); // pop has happened here
                end
                timer = 0;
                while (!empty) begin // drain, later words skip dropped samples
                    step_cycle(1'b1);
                    timer = timer + 1;
                    if (timer > timeout) fail_run("timed out waiting for the FIFO to drain");
                end
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tests/oht_properties.sv
`timescale 1ns/100ps

module oht_properties import oht_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  enque,
    input logic [fifo_cnt_w-1:0] fifo_count,
    input logic                  perm_fail
);

    // spare slot has to absorb the word in flight
    no_enq_when_occupied: assert property (@(posedge clk) disable iff (!rst)
        !(enque && fifo_count == fifo_cnt_w'(fifo_depth)))
        else $error("enqueue into a completely occupied FIFO");

    // compactor gains at most 8 bits per cycle so words come 4+ cycles apart
    enq_spacing: assert property (@(posedge clk) disable iff (!rst)
        enque |-> !($past(enque) || $past(enque, 2) || $past(enque, 3)))
        else $error("two enqueues less than four cycles apart");

    // only reset clears a dead source
    fail_sticky: assert property (@(posedge clk) disable iff (!rst)
        ($past(rst) && $past(perm_fail)) |-> perm_fail)
        else $error("perm_fail dropped without reset");

endmodule

bind cond_fifo oht_properties u_fifo_props (
    .clk        (clk),
    .rst        (rst),
    .enque      (enque),
    .fifo_count (count),
    .perm_fail  (1'b0)
);

bind es_health_test oht_properties u_health_props (
    .clk        (clk),
    .rst        (rst),
    .enque      (1'b0),
    .fifo_count ('0),
    .perm_fail  (perm_fail)
);

// File: logic/oht_top.sv
`timescale 1ns/100ps

module oht_top import oht_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [es_sources-1:0] es_in,       // 0-7 latch, 8-15 jitter
    input  logic                  deque,       // conditioner pop
    output logic [cond_width-1:0] cond_out,
    output logic                  full,
    output logic                  empty,
    output logic [es_sources-1:0] rd_good_arr  // per source health
);

    logic [es_sources-1:0]   valid_arr;
    logic [es_sources-1:0]   fail_arr;
    logic                    any_valid;
    logic [sample_width-1:0] word_data;
    logic [sample_width-1:0] word_mask;
    logic                    word_valid;
    logic [cond_width-1:0]   pack_data;
    logic                    pack_valid;

    assign rd_good_arr = valid_arr & ~fail_arr;
    assign any_valid   = |valid_arr; // start writing once anything warmed up

    for (genvar i = 0; i < latch_sources; i++) begin : gen_latch
        es_health_test u_latch_test (
            .clk       (clk),
            .rst       (rst),
            .sample    (es_in[i]),
            .valid     (valid_arr[i]),
            .perm_fail (fail_arr[i])
        );
    end

    for (genvar j = 0; j < jitter_sources; j++) begin : gen_jitter
        es_health_test u_jitter_test (
            .clk       (clk),
            .rst       (rst),
            .sample    (es_in[latch_sources+j]),
            .valid     (valid_arr[latch_sources+j]),
            .perm_fail (fail_arr[latch_sources+j])
        );
    end

    es_sample_buffer u_sample_buffer (
        .clk        (clk),
        .rst        (rst),
        .es_in      (es_in),
        .good_arr   (rd_good_arr),
        .any_valid  (any_valid),
        .full       (full),
        .word_data  (word_data),
        .word_mask  (word_mask),
        .word_valid (word_valid)
    );

    bit_compactor u_bit_compactor (
        .clk        (clk),
        .rst        (rst),
        .word_data  (word_data),
        .word_mask  (word_mask),
        .word_valid (word_valid),
        .pack_data  (pack_data),
        .pack_valid (pack_valid)
    );

    cond_fifo u_cond_fifo (
        .clk   (clk),
        .rst   (rst),
        .wdata (pack_data),
        .enque (pack_valid),
        .deque (deque),
        .rdata (cond_out),
        .full  (full),  // also stalls the buffer
        .empty (empty)
    );

endmodule

// File: logic/cond_fifo.sv
`timescale 1ns/100ps

module cond_fifo import oht_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [cond_width-1:0] wdata,
    input  logic                  enque,
    input  logic                  deque,
    output logic [cond_width-1:0] rdata,   // head word, fall-through
    output logic                  full,    // early, one slot spare
    output logic                  empty
);

    logic [cond_width-1:0]  mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0]  count;    // entries stored
    logic                   do_enq;
    logic                   do_deq;

    assign do_enq = enque && (count != fifo_cnt_w'(fifo_depth)); // drop when truly full
    assign do_deq = deque && !empty;  // pop on empty ignored

    assign empty = (count == '0);
    assign full  = (count >= fifo_cnt_w'(fifo_depth - 1));
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/bit_compactor.sv
`timescale 1ns/100ps

module bit_compactor import oht_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [sample_width-1:0] word_data,
    input  logic [sample_width-1:0] word_mask,   // 1 = healthy source
    input  logic                    word_valid,
    output logic [cond_width-1:0]   pack_data,
    output logic                    pack_valid
);

    logic [cond_width+sample_width-1:0] acc;       // packed bits, oldest at bit 0
    logic [cond_width+sample_width-1:0] acc_next;
    logic [fill_w-1:0]                  fill;      // bits held in acc
    logic [fill_w-1:0]                  fill_next;

    // append masked bits, lowest source first
    always_comb begin
        acc_next  = acc;
        fill_next = fill;
        if (word_valid) begin
            for (int i = 0; i < sample_width; i++) begin
                if (word_mask[i]) begin
                    acc_next[fill_next] = word_data[i];
                    fill_next           = fill_next + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fill       <= '0;
            pack_valid <= 1'b0;
        end else begin
            pack_valid <= 1'b0;
            if (fill_next >= fill_w'(cond_width)) begin
                pack_valid <= 1'b1;
                fill       <= fill_next - fill_w'(cond_width); // leftover carries on
            end else begin
                fill <= fill_next;
            end
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        if (fill_next >= fill_w'(cond_width)) begin
            pack_data <= acc_next[cond_width-1:0];
            acc       <= acc_next >> cond_width; // remainder down to bit 0
        end else begin
            acc <= acc_next;
        end
    end

endmodule

// File: logic/es_sample_buffer.sv
`timescale 1ns/100ps

module es_sample_buffer import oht_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [es_sources-1:0]   es_in,      // raw bits, latch low half
    input  logic [es_sources-1:0]   good_arr,   // valid and not failed
    input  logic                    any_valid,  // some source warmed up
    input  logic                    full,       // fifo near full, stall
    output logic [sample_width-1:0] word_data,
    output logic [sample_width-1:0] word_mask,
    output logic                    word_valid
);

    logic [sample_width-1:0] mem [buf_depth]; // inferred dual port ring

    logic [buf_addr_w-1:0]   wr_ptr;
    logic [buf_addr_w-1:0]   rd_ptr;
    logic                    rd_started;  // reader trailing the writer
    logic                    wr_en;
    logic                    rd_en;
    logic [sample_width-1:0] wr_word;
    logic [sample_width-1:0] rd_mask;
    logic [sample_width-1:0] rd_q;        // memory read stage
    logic [sample_width-1:0] mask_q;      // mask travels beside data
    logic                    rd_q_valid;

    // ptr lsb picks the half, even latch, odd jitter
    assign wr_word = wr_ptr[0] ? es_in[latch_sources +: sample_width]
                               : es_in[0 +: sample_width];
    assign rd_mask = rd_ptr[0] ? good_arr[latch_sources +: sample_width]
                               : good_arr[0 +: sample_width];

    // full freezes both sides, samples meanwhile are dropped
    assign wr_en = any_valid && !full;
    assign rd_en = rd_started && !full && (rd_ptr != wr_ptr);

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            rd_started <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at buf_depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // reader starts once the lead is written, stays on
            if (wr_ptr > buf_addr_w'(read_lead)) begin
                rd_started <= 1'b1;
            end
        end
    end

    // memory write port and read stage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
        if (rd_en) begin
            rd_q   <= mem[rd_ptr];
            mask_q <= rd_mask; // mask as seen at issue
        end
    end

    // output register stage
    always_ff @(posedge clk) begin
        word_data <= rd_q;
        word_mask <= mask_q;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_q_valid <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            rd_q_valid <= rd_en;
            word_valid <= rd_q_valid; // two cycles after issue
        end
    end

endmodule

// File: logic/es_health_test.sv
`timescale 1ns/100ps

module es_health_test import oht_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic sample,     // one raw bit per cycle
    output logic valid,      // warm-up done
    output logic perm_fail   // sticky until reset
);

    logic [warm_cnt_w-1:0] warm_cnt;    // samples seen, saturates
    logic [run_cnt_w-1:0]  run_len;     // length of the current run
    logic [run_cnt_w-1:0]  run_next;
    logic                  last_sample; // previous bit for run compare

    // run length including this cycle's sample
    always_comb begin
        if (warm_cnt == '0 || sample != last_sample) begin
            run_next = run_cnt_w'(1); // first sample or value changed
        end else if (run_len == run_cnt_w'(rct_limit)) begin
            run_next = run_len; // hold at limit, flag already set
        end else begin
            run_next = run_len + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        last_sample <= sample;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            warm_cnt  <= '0;
            run_len   <= '0;
            valid     <= 1'b0;
            perm_fail <= 1'b0;
        end else begin
            if (warm_cnt != warm_cnt_w'(warmup_samples)) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
            run_len <= run_next;
            // valid goes up at the edge taking the last warm-up sample
            valid <= (warm_cnt >= warm_cnt_w'(warmup_samples - 1));
            // repetition count test
            if (run_next == run_cnt_w'(rct_limit)) begin
                perm_fail <= 1'b1;
            end
        end
    end

endmodule

// File: logic/oht_pkg.sv
package oht_pkg;

    // source counts
    localparam int latch_sources  = 8;
    localparam int jitter_sources = 8;
    localparam int es_sources     = latch_sources + jitter_sources; // latch low, jitter high

    // sample ring memory
    localparam int sample_width = 8;   // one half of the sources per word
    localparam int buf_depth    = 32;  // even = latch, odd = jitter
    localparam int read_lead    = 16;  // words written before the reader starts

    // health test limits
    localparam int warmup_samples = 16;
    localparam int rct_limit      = 12; // identical samples in a row => dead source

    // conditioner side
    localparam int cond_width = 32;
    localparam int fifo_depth = 8;

    // derived widths
    localparam int buf_addr_w  = $clog2(buf_depth);
    localparam int fifo_addr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);
    localparam int fill_w      = $clog2(cond_width + sample_width);
    localparam int warm_cnt_w  = $clog2(warmup_samples + 1);
    localparam int run_cnt_w   = $clog2(rct_limit + 1);

endpackage
